// File: logic/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    // Memory geometry, 24C16 style
    localparam int mem_depth = 2048;
    localparam int addr_w    = 11;

    // Upper nibble of the select byte
    localparam logic [3:0] device_id = 4'b1010;

    localparam int sync_stages = 2; // Depth of bus line synchronizers

    // Transaction states
    typedef enum logic [2:0] {
        st_idle,
        st_dev_sel,
        st_word_addr,
        st_write_data,
        st_read_data,
        st_read_ack,
        st_ignore
    } proto_state_t;

endpackage

`default_nettype wire

// File: logic/line_sampler.sv
`timescale 1ns/10ps
`default_nettype none

module line_sampler (
    input  wire  sda,
    input  wire  arst_n,
    input  wire  scl,
    input  wire  ser_data_in,
    output logic scl_rise,
    output logic scl_fall,
    output logic start_seen,
    output logic stop_seen,
    output logic data_bit
);

    logic [eeprom_pkg::sync_stages-1:0] scl_sync;
    logic [eeprom_pkg::sync_stages-1:0] data_sync;
    logic scl_s;
    logic data_s;
    logic scl_q;
    logic data_q;

    assign scl_s    = scl_sync[eeprom_pkg::sync_stages-1];
    assign data_s   = data_sync[eeprom_pkg::sync_stages-1];
    assign data_bit = data_q;   // Aligned with the strobes

    // Idle bus is high on both lines
    always_ff @(posedge sda or negedge arst_n)
    begin
        if (!arst_n)
        begin
            scl_sync   <= '1;
            data_sync  <= '1;
            scl_q      <= 1'b1;
            data_q     <= 1'b1;
            scl_rise   <= 1'b0;
            scl_fall   <= 1'b0;
            start_seen <= 1'b0;
            stop_seen  <= 1'b0;
        end
        else
        begin
            scl_sync  <= {scl_sync[eeprom_pkg::sync_stages-2:0], scl};
            data_sync <= {data_sync[eeprom_pkg::sync_stages-2:0], ser_data_in};
            scl_q     <= scl_s;
            data_q    <= data_s;

            scl_rise   <= scl_s & ~scl_q;
            scl_fall   <= ~scl_s & scl_q;
            // Data moving while clock stays high
            start_seen <= scl_s & scl_q & data_q & ~data_s;
            stop_seen  <= scl_s & scl_q & ~data_q & data_s;
        end
    end

endmodule

`default_nettype wire

// File: logic/byte_shifter.sv
`timescale 1ns/10ps
`default_nettype none

module byte_shifter (
    input  wire        sda,
    input  wire        arst_n,
    input  wire        scl_rise,
    input  wire        scl_fall,
    input  wire        start_seen,
    input  wire        data_bit,
    input  wire        transmit,
    input  wire        ack_enable,
    input  wire        load_tx,
    input  wire  [7:0] tx_byte,
    output logic [7:0] rx_byte,
    output logic       byte_done,
    output logic       ack_done,
    output logic       master_ack,
    output logic       ser_data_oe
);

    logic [3:0] slot_cnt;   // Counts scl rises, 9 is the ACK slot
    logic [7:0] rx_shift;
    logic [7:0] tx_shift;
    logic       mid_byte;

    assign rx_byte  = rx_shift;
    assign mid_byte = (slot_cnt != 4'd0) && (slot_cnt < 4'd8);

    always_ff @(posedge sda or negedge arst_n)
    begin
        if (!arst_n)
        begin
            slot_cnt    <= '0;
            byte_done   <= 1'b0;
            ack_done    <= 1'b0;
            master_ack  <= 1'b0;
            ser_data_oe <= 1'b0;
        end
        else
        begin
            byte_done <= 1'b0;
            ack_done  <= 1'b0;

            if (start_seen)
            begin
                slot_cnt    <= '0;
                ser_data_oe <= 1'b0;
            end
            else if (load_tx)
                ser_data_oe <= ~tx_byte[7];   // First bit of a read byte
            else if (scl_rise)
            begin
                if (slot_cnt == 4'd8)
                    master_ack <= ~data_bit;
                if (slot_cnt < 4'd9)
                    slot_cnt <= slot_cnt + 4'd1;
            end
            else if (scl_fall)
            begin
                if (slot_cnt == 4'd8)
                begin
                    // Eighth bit complete, ACK slot follows
                    byte_done   <= 1'b1;
                    ser_data_oe <= ~transmit & ack_enable;
                end
                else if (slot_cnt == 4'd9)
                begin
                    ack_done    <= 1'b1;
                    slot_cnt    <= '0;
                    ser_data_oe <= 1'b0;
                end
                else if (mid_byte)
                    ser_data_oe <= transmit & ~tx_shift[6];
            end
        end
    end

    always_ff @(posedge sda)
    begin
        if (load_tx)
            tx_shift <= tx_byte;
        else if (scl_fall && transmit && mid_byte)
            tx_shift <= {tx_shift[6:0], 1'b0};

        if (scl_rise && slot_cnt < 4'd8)
            rx_shift <= {rx_shift[6:0], data_bit};   // MSB first
    end

endmodule

`default_nettype wire

// File: logic/eeprom_protocol.sv
`timescale 1ns/10ps
`default_nettype none

module eeprom_protocol (
    input  wire                           sda,
    input  wire                           arst_n,
    input  wire                           start_seen,
    input  wire                           stop_seen,
    input  wire                           byte_done,
    input  wire                           ack_done,
    input  wire                           master_ack,
    input  wire  [7:0]                    rx_byte,
    input  wire  [7:0]                    mem_rdata,
    output logic                          transmit,
    output logic                          ack_enable,
    output logic                          load_tx,
    output logic [7:0]                    tx_byte,
    output logic                          mem_we,
    output logic [eeprom_pkg::addr_w-1:0] mem_addr,
    output logic [7:0]                    mem_wdata
);

    eeprom_pkg::proto_state_t state;

    logic [eeprom_pkg::addr_w-9:0] blk;   // Block bits from write select
    logic [eeprom_pkg::addr_w-1:0] ptr;
    logic                          fetch;
    logic                          fetch_q;
    logic                          id_match;

    assign mem_addr = ptr;
    assign id_match = (rx_byte[7:4] == eeprom_pkg::device_id);
    assign transmit = (state == eeprom_pkg::st_read_data) ||
                      (state == eeprom_pkg::st_read_ack);

    // Decides the slave ACK for the byte just shifted in
    always_comb
    begin
        case (state)
            eeprom_pkg::st_dev_sel:    ack_enable = id_match;
            eeprom_pkg::st_word_addr:  ack_enable = 1'b1;
            eeprom_pkg::st_write_data: ack_enable = 1'b1;
            default:                   ack_enable = 1'b0;
        endcase
    end

    always_ff @(posedge sda or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state   <= eeprom_pkg::st_idle;
            blk     <= '0;
            ptr     <= '0;
            mem_we  <= 1'b0;
            fetch   <= 1'b0;
            fetch_q <= 1'b0;
            load_tx <= 1'b0;
        end
        else
        begin
            mem_we  <= 1'b0;
            fetch   <= 1'b0;
            fetch_q <= fetch;
            load_tx <= fetch_q;   // Read data settled by now

            // Write lands on this edge, pointer moves with it
            if (mem_we)
                ptr <= ptr + 1'b1;

            if (stop_seen)
                state <= eeprom_pkg::st_idle;
            else if (start_seen)
                state <= eeprom_pkg::st_dev_sel;
            else
            begin
                case (state)
                    eeprom_pkg::st_dev_sel:
                        if (byte_done)
                        begin
                            if (!id_match)
                                state <= eeprom_pkg::st_ignore;
                            else if (rx_byte[0])
                                state <= eeprom_pkg::st_read_data;
                            else
                            begin
                                blk   <= rx_byte[3:1];
                                state <= eeprom_pkg::st_word_addr;
                            end
                        end
                    eeprom_pkg::st_word_addr:
                        if (byte_done)
                        begin
                            ptr   <= {blk, rx_byte};
                            state <= eeprom_pkg::st_write_data;
                        end
                    eeprom_pkg::st_write_data:
                        if (byte_done)
                            mem_we <= 1'b1;
                    eeprom_pkg::st_read_data:
                        if (ack_done)
                            fetch <= 1'b1;   // Select ACK over, first byte
                        else if (byte_done)
                            state <= eeprom_pkg::st_read_ack;
                    eeprom_pkg::st_read_ack:
                        if (ack_done)
                        begin
                            if (master_ack)
                            begin
                                ptr   <= ptr + 1'b1;
                                fetch <= 1'b1;
                                state <= eeprom_pkg::st_read_data;
                            end
                            else
                                state <= eeprom_pkg::st_idle;   // Master NACK ends the read
                        end
                    default:
                        state <= state;
                endcase
            end
        end
    end

    always_ff @(posedge sda)
    begin
        if (byte_done)
            mem_wdata <= rx_byte;
        if (fetch_q)
            tx_byte <= mem_rdata;
    end

endmodule

`default_nettype wire

// File: logic/eeprom_array.sv
`timescale 1ns/10ps
`default_nettype none

module eeprom_array (
    input  wire                           sda,
    input  wire                           mem_we,
    input  wire  [eeprom_pkg::addr_w-1:0] mem_addr,
    input  wire  [7:0]                    mem_wdata,
    output logic [7:0]                    mem_rdata
);

    logic [7:0] mem [eeprom_pkg::mem_depth];

    always_ff @(posedge sda)
    begin
        if (mem_we)
            mem[mem_addr] <= mem_wdata;
        mem_rdata <= mem[mem_addr];   // Old data on a same-cycle write
    end

endmodule

`default_nettype wire

// File: logic/eeprom_top.sv
`timescale 1ns/10ps
`default_nettype none

module eeprom_top (
    input  wire sda,
    input  wire arst_n,
    input  wire scl,
    input  wire ser_data_in,
    output wire ser_data_oe
);

    logic                          scl_rise;
    logic                          scl_fall;
    logic                          start_seen;
    logic                          stop_seen;
    logic                          data_bit;
    logic [7:0]                    rx_byte;
    logic                          byte_done;
    logic                          ack_done;
    logic                          master_ack;
    logic                          transmit;
    logic                          ack_enable;
    logic                          load_tx;
    logic [7:0]                    tx_byte;
    logic                          mem_we;
    logic [eeprom_pkg::addr_w-1:0] mem_addr;
    logic [7:0]                    mem_wdata;
    logic [7:0]                    mem_rdata;

    line_sampler u_sampler (
        .sda         (sda),
        .arst_n      (arst_n),
        .scl         (scl),
        .ser_data_in (ser_data_in),
        .scl_rise    (scl_rise),
        .scl_fall    (scl_fall),
        .start_seen  (start_seen),
        .stop_seen   (stop_seen),
        .data_bit    (data_bit)
    );

    byte_shifter u_shifter (
        .sda         (sda),
        .arst_n      (arst_n),
        .scl_rise    (scl_rise),
        .scl_fall    (scl_fall),
        .start_seen  (start_seen),
        .data_bit    (data_bit),
        .transmit    (transmit),
        .ack_enable  (ack_enable),
        .load_tx     (load_tx),
        .tx_byte     (tx_byte),
        .rx_byte     (rx_byte),
        .byte_done   (byte_done),
        .ack_done    (ack_done),
        .master_ack  (master_ack),
        .ser_data_oe (ser_data_oe)
    );

    eeprom_protocol u_protocol (
        .sda        (sda),
        .arst_n     (arst_n),
        .start_seen (start_seen),
        .stop_seen  (stop_seen),
        .byte_done  (byte_done),
        .ack_done   (ack_done),
        .master_ack (master_ack),
        .rx_byte    (rx_byte),
        .mem_rdata  (mem_rdata),
        .transmit   (transmit),
        .ack_enable (ack_enable),
        .load_tx    (load_tx),
        .tx_byte    (tx_byte),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

    eeprom_array u_array (
        .sda       (sda),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// File: testbench/eeprom_properties.sv
`timescale 1ns/10ps
`default_nettype none

module eeprom_properties (
    input wire sda,
    input wire arst_n,
    input wire ser_data_oe,
    input wire mem_we,
    input wire load_tx
);

    // Slave keeps the data line released during reset
    oe_idle_in_reset: assert property (@(posedge sda) !arst_n |-> !ser_data_oe)
        else $error("ser_data_oe asserted while arst_n is low");

    we_single_cycle: assert property (@(posedge sda) disable iff (!arst_n)
        mem_we |=> !mem_we)
        else $error("mem_we held for more than one cycle");

    load_we_exclusive: assert property (@(posedge sda) disable iff (!arst_n)
        !(load_tx && mem_we))
        else $error("load_tx and mem_we in the same cycle");

endmodule

bind eeprom_top eeprom_properties u_properties (
    .sda         (sda),
    .arst_n      (arst_n),
    .ser_data_oe (ser_data_oe),
    .mem_we      (mem_we),
    .load_tx     (load_tx)
);

`default_nettype wire

// File: testbench/eeprom_tb.sv
`timescale 1ns/10ps
`default_nettype none

module eeprom_tb;

    localparam int quarter = 10;   // Quarter of an scl period, in clocks
    localparam int half    = 20;
    // 54 bytes x 9 bits x 40 clocks is about 20k, plus start and stop, wide margin
    localparam int timeout_cycles = 200_000;

    logic sda;
    logic arst_n;
    logic scl;
    logic master_pull;
    logic bus_line;
    wire  ser_data_oe;

    logic [7:0]                    ref_mem [eeprom_pkg::mem_depth];
    logic [eeprom_pkg::addr_w-1:0] ref_ptr;
    logic [7:0]                    payload [$];
    logic [7:0]                    exp_q [$];
    logic [7:0]                    act_q [$];
    string                         name_q [$];
    logic [31:0]                   rng_state;
    int                            failures;
    int                            cycle_count;

    assign bus_line = ~(master_pull | ser_data_oe);   // Open drain, low wins

    eeprom_top DUT (
        .sda         (sda),
        .arst_n      (arst_n),
        .scl         (scl),
        .ser_data_in (bus_line),
        .ser_data_oe (ser_data_oe)
    );

    always #5 sda = ~sda;

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Byte the device returns for a read at the given pointer
    function automatic logic [7:0] expected_read(input logic [eeprom_pkg::addr_w-1:0] ptr);
        return ref_mem[ptr];
    endfunction

    task automatic end_run();
        if (failures == 0)
        begin
            $display("TESTBENCH PASSED");
            $finish;
        end
        else
        begin
            $display("TESTBENCH FAILED");
            $fatal(1, "run stopped at the first error");
        end
    endtask

    task automatic check_value(input string test_name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s expected %02h actual %02h", test_name, expected, actual);
            failures++;
            end_run();
        end
    endtask

    task automatic next_random(output logic [31:0] value);
        rng_state = xorshift(rng_state);
        value = rng_state;
    endtask

    task automatic wait_cycles(input int count);
        repeat (count) @(negedge sda);
    endtask

    // One scl period, level sampled in the middle of the high phase
    task automatic clock_bit(input logic pull, output logic level);
        master_pull = pull;
        wait_cycles(quarter);
        scl = 1'b1;
        wait_cycles(quarter);
        level = bus_line;
        wait_cycles(quarter);
        scl = 1'b0;
        wait_cycles(quarter);
    endtask

    task automatic bus_start();
        master_pull = 1'b0;
        wait_cycles(quarter);
        scl = 1'b1;
        wait_cycles(half);
        master_pull = 1'b1;   // Data falls under a high scl
        wait_cycles(half);
        scl = 1'b0;
        wait_cycles(quarter);
    endtask

    task automatic bus_stop();
        master_pull = 1'b1;
        wait_cycles(quarter);
        scl = 1'b1;
        wait_cycles(half);
        master_pull = 1'b0;
        wait_cycles(half);
    endtask

    task automatic send_bits(input logic [7:0] data, input int count);
        logic level;
        for (int i = 7; i > 7 - count; i--)
            clock_bit(~data[i], level);
    endtask

    task automatic send_byte(input logic [7:0] data, input logic want_ack, input string what);
        logic level;
        send_bits(data, 8);
        clock_bit(1'b0, level);   // Line released for the slave ACK
        if (level !== ~want_ack)
        begin
            if (want_ack)
                $display("ERROR: the slave gave no ACK on the %s", what);
            else
                $display("ERROR: the slave acknowledged the %s, which it should ignore", what);
            failures++;
            end_run();
        end
    endtask

    task automatic receive_byte(input logic ack, output logic [7:0] data);
        logic level;
        data = '0;
        for (int i = 0; i < 8; i++)
        begin
            clock_bit(1'b0, level);
            data = {data[6:0], level};
        end
        clock_bit(ack, level);
    endtask

    // Dummy write, leaves the bus open for a repeated START
    task automatic set_pointer(input logic [10:0] addr);
        bus_start();
        send_byte({eeprom_pkg::device_id, addr[10:8], 1'b0}, 1'b1, "write select");
        send_byte(addr[7:0], 1'b1, "word address");
        ref_ptr = addr;
    endtask

    task automatic write_payload(input logic [10:0] addr);
        set_pointer(addr);
        foreach (payload[i])
        begin
            send_byte(payload[i], 1'b1, "write data");
            ref_mem[ref_ptr] = payload[i];
            ref_ptr = ref_ptr + 11'd1;
        end
        bus_stop();
    endtask

    task automatic read_sequence(input logic [2:0] blk, input int count, input string test_name);
        logic [7:0] expected;
        logic [7:0] got;
        bus_start();
        send_byte({eeprom_pkg::device_id, blk, 1'b1}, 1'b1, "read select");
        for (int i = 0; i < count; i++)
        begin
            expected = expected_read(ref_ptr);
            receive_byte(i != count - 1, got);   // NACK on the last byte
            exp_q.push_back(expected);
            act_q.push_back(got);
            name_q.push_back(test_name);
            if (i != count - 1)
                ref_ptr = ref_ptr + 11'd1;
        end
        bus_stop();
    endtask

    always @(posedge sda)
    begin
        string      test_name;
        logic [7:0] exp_byte;
        logic [7:0] act_byte;
        while (act_q.size() != 0)
        begin
            test_name = name_q.pop_front();
            exp_byte  = exp_q.pop_front();
            act_byte  = act_q.pop_front();
            check_value(test_name, exp_byte, act_byte);
        end
    end

    always @(posedge sda)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_cycles)
        begin
            $display("ERROR: timeout, the run went past %0d clock cycles", timeout_cycles);
            failures++;
            end_run();
        end
    end

    initial
    begin
        logic [31:0] r;
        logic [10:0] addr_a;
        logic [10:0] addr_b;
        logic [3:0]  foreign_id;
        sda         = 1'b0;
        arst_n      = 1'b0;
        scl         = 1'b1;
        master_pull = 1'b0;
        rng_state   = 32'h570c_9a22;
        failures    = 0;
        cycle_count = 0;
        repeat (10) @(negedge sda);
        arst_n = 1'b1;
        wait_cycles(half);

        // Select decode, foreign identifier is ignored
        bus_start();
        send_byte({eeprom_pkg::device_id, 3'b000, 1'b0}, 1'b1, "select with identifier 1010");
        bus_stop();
        next_random(r);
        foreign_id = r[3:0];
        if (foreign_id == eeprom_pkg::device_id)
            foreign_id = foreign_id ^ 4'b0001;
        next_random(r);
        addr_a = r[10:0];
        payload.delete();
        payload.push_back(r[23:16]);
        write_payload(addr_a);
        bus_start();
        send_byte({foreign_id, addr_a[10:8], 1'b0}, 1'b0, "select with a foreign identifier");
        send_byte(addr_a[7:0], 1'b0, "word address after a foreign select");
        send_byte(~r[23:16], 1'b0, "data byte after a foreign select");
        bus_stop();
        set_pointer(addr_a);
        read_sequence(addr_a[10:8], 1, "foreign_select_write");

        // Single write, random read through a repeated START
        next_random(r);
        addr_b = r[10:0];
        payload.delete();
        payload.push_back(r[31:24]);
        write_payload(addr_b);
        set_pointer(addr_b);
        read_sequence(addr_b[10:8], 1, "single_write");

        next_random(r);
        addr_a = r[10:0];
        payload.delete();
        repeat (8)
        begin
            next_random(r);
            payload.push_back(r[7:0]);
        end
        write_payload(addr_a);
        set_pointer(addr_a);
        read_sequence(addr_a[10:8], 8, "sequential_rw");

        // STOP after four data bits stores nothing
        set_pointer(addr_b);
        next_random(r);
        send_bits(r[7:0], 4);
        bus_stop();
        set_pointer(addr_b);
        read_sequence(addr_b[10:8], 1, "stop_mid_byte");

        // Pointer wraps from 2047 to 0
        next_random(r);
        payload.delete();
        payload.push_back(r[7:0]);
        write_payload(11'd0);
        payload.delete();
        payload.push_back(r[15:8]);
        write_payload(11'h7ff);
        read_sequence(3'b111, 1, "pointer_wrap");

        while (act_q.size() != 0)
            @(negedge sda);
        wait_cycles(quarter);
        end_run();
    end

endmodule

`default_nettype wire

// File: i2c_eeprom.f
logic/eeprom_pkg.sv
logic/line_sampler.sv
logic/byte_shifter.sv
logic/eeprom_protocol.sv
logic/eeprom_array.sv
logic/eeprom_top.sv
testbench/eeprom_properties.sv
testbench/eeprom_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = eeprom_tb
FILELIST = i2c_eeprom.f
OBJ_DIR  = obj_dir
LOG      = sim.log

FAIL_TEXT = TESTBENCH FAILED
PASS_TEXT = TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then exit 1; fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
